/* sweepAcqPkg.sv */
package sweepAcqPkg;

    ////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////
    localparam int DAC_WIDTH         = 10;
    localparam int DATA_WIDTH        = 16;
    localparam int PKG_COUNT_WIDTH   = 16;
    localparam int WORDS_PER_PACKAGE = 10;
    localparam int FIFO_DEPTH        = 32;
    localparam int FIFO_ADDR_WIDTH   = $clog2(FIFO_DEPTH);
    localparam int WORD_COUNT_WIDTH  = $clog2(WORDS_PER_PACKAGE);
    localparam int LD_COUNT_WIDTH    = $clog2(DAC_WIDTH);

    // Whole packages the FIFO can hold at once
    localparam int PEND_WIDTH = $clog2(FIFO_DEPTH / WORDS_PER_PACKAGE + 1);

    // Settle time after slow control load
    localparam int SC_SETTLE_CYCLES   = 40;
    localparam int SETTLE_COUNT_WIDTH = $clog2(SC_SETTLE_CYCLES + 1);

    ////////////////////////////////////////////////////////////////////
    // Marker words
    ////////////////////////////////////////////////////////////////////
    localparam logic [DATA_WIDTH-1:0] HEADER_WORD = 16'h5341;
    localparam logic [DATA_WIDTH-1:0] TAIL_WORD   = 16'hFF45;
    localparam logic [3:0]            PARAM_TAG   = 4'hD;

    typedef enum logic [3:0] {
        Idle,
        HeaderOut,
        ParamOut,
        LoadParam,
        WaitLoad,
        StartAcq,
        WaitPackage,
        ReadWord,
        LatchWord,
        OutWord,
        CheckDacDone,
        CheckAllDone,
        TailOut,
        WaitTransmit
    } sweepStateT;

    typedef enum logic [1:0] {
        LdIdle,
        LdShift,
        LdDone
    } loaderStateT;

endpackage

/* acqDataFifo.sv */
module acqDataFifo import sweepAcqPkg::*; (
    input  logic                  Clk,
    input  logic                  reset_n,
    input  logic [DATA_WIDTH-1:0] ParallelData,
    input  logic                  ParallelDataEn,
    input  logic                  FifoRden,
    output logic [DATA_WIDTH-1:0] FifoData
);

    logic [DATA_WIDTH-1:0]      mem [FIFO_DEPTH];
    logic [FIFO_ADDR_WIDTH-1:0] wrPtr;
    logic [FIFO_ADDR_WIDTH-1:0] rdPtr;
    logic [FIFO_ADDR_WIDTH:0]   count;
    logic                       full;
    logic                       empty;
    logic                       doWrite;
    logic                       doRead;

    assign full    = (count == FIFO_DEPTH);
    assign empty   = (count == '0);
    // Drop writes when full, ignore reads when empty
    assign doWrite = ParallelDataEn && !full;
    assign doRead  = FifoRden && !empty;

    // Pointers and occupancy
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite)
                wrPtr <= wrPtr + 1'b1;
            if (doRead)
                rdPtr <= rdPtr + 1'b1;
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and registered head word
    always_ff @(posedge Clk) begin
        if (doWrite)
            mem[wrPtr] <= ParallelData;
        if (doRead)
            FifoData <= mem[rdPtr];
    end

endmodule

/* scParamLoader.sv */
module scParamLoader import sweepAcqPkg::*; (
    input  logic                 Clk,
    input  logic                 reset_n,
    input  logic [DAC_WIDTH-1:0] OutDac0,
    input  logic                 LoadScParam,
    output logic                 ScSerialData,
    output logic                 ScSerialEn,
    output logic                 ScConfigDone
);

    loaderStateT               state;
    logic [DAC_WIDTH-1:0]      shiftReg;
    logic [LD_COUNT_WIDTH-1:0] bitCount;

    // MSB of the shift register goes out first
    assign ScSerialData = shiftReg[DAC_WIDTH-1];
    assign ScSerialEn   = (state == LdShift);
    assign ScConfigDone = (state == LdDone);

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= LdIdle;
            shiftReg <= '0;
            bitCount <= '0;
        end else begin
            case (state)
                LdIdle: begin
                    // Requests are only taken here
                    if (LoadScParam) begin
                        shiftReg <= OutDac0;
                        bitCount <= '0;
                        state    <= LdShift;
                    end
                end
                LdShift: begin
                    shiftReg <= {shiftReg[DAC_WIDTH-2:0], 1'b0};
                    if (bitCount == DAC_WIDTH - 1) begin
                        state <= LdDone;
                    end else begin
                        bitCount <= bitCount + 1'b1;
                    end
                end
                LdDone:  state <= LdIdle;
                default: state <= LdIdle;
            endcase
        end
    end

endmodule

/* sweepAcqControl.sv */
module sweepAcqControl import sweepAcqPkg::*; (
    input  logic                       Clk,
    input  logic                       reset_n,
    input  logic                       SweepStart,
    input  logic                       DataTransmitDone,
    input  logic [DAC_WIDTH-1:0]       StartDac0,
    input  logic [DAC_WIDTH-1:0]       EndDac0,
    input  logic [PKG_COUNT_WIDTH-1:0] MaxPackageNumber,
    input  logic                       ParallelDataEn,
    input  logic [DATA_WIDTH-1:0]      FifoData,
    input  logic                       ScConfigDone,
    output logic                       FifoRden,
    output logic [DAC_WIDTH-1:0]       OutDac0,
    output logic                       LoadScParam,
    output logic                       SingleAcqStart,
    output logic                       OneDacDone,
    output logic                       AcqDone,
    output logic [DATA_WIDTH-1:0]      SweepAcqData,
    output logic                       SweepAcqDataEn
);

    sweepStateT                  state;
    logic [DAC_WIDTH-1:0]        currentDac;
    logic [PKG_COUNT_WIDTH-1:0]  pkgCount;
    logic [WORD_COUNT_WIDTH-1:0] wordCount;
    logic [SETTLE_COUNT_WIDTH-1:0] settleCount;
    logic [WORD_COUNT_WIDTH-1:0] inWordCount;
    logic                        pkgDone;
    logic [PEND_WIDTH-1:0]       pendingPkgs;
    logic                        takePackage;

    // Slow control chain wants the code bit-reversed
    function automatic logic [DAC_WIDTH-1:0] reverseBits(input logic [DAC_WIDTH-1:0] code);
        logic [DAC_WIDTH-1:0] result;
        for (int i = 0; i < DAC_WIDTH; i++)
            result[i] = code[DAC_WIDTH-1-i];
        return result;
    endfunction

    assign takePackage = (state == WaitPackage) && (pendingPkgs != '0);

    //////////////////////////////////////////////////////////////////////
    // Sweep FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= Idle;
            currentDac     <= '0;
            pkgCount       <= '0;
            wordCount      <= '0;
            settleCount    <= '0;
            FifoRden       <= 1'b0;
            OutDac0        <= '0;
            LoadScParam    <= 1'b0;
            SingleAcqStart <= 1'b0;
            OneDacDone     <= 1'b0;
            AcqDone        <= 1'b0;
            SweepAcqData   <= '0;
            SweepAcqDataEn <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    currentDac  <= StartDac0;
                    pkgCount    <= '0;
                    wordCount   <= '0;
                    settleCount <= '0;
                    if (SweepStart) begin
                        SweepAcqData <= HEADER_WORD;
                        state        <= HeaderOut;
                    end
                end
                HeaderOut: begin
                    SweepAcqDataEn <= 1'b1;
                    state          <= ParamOut;
                end
                ParamOut: begin
                    SweepAcqDataEn <= 1'b0;
                    SweepAcqData   <= {PARAM_TAG, 2'b00, currentDac};
                    OutDac0        <= reverseBits(currentDac);
                    state          <= LoadParam;
                end
                LoadParam: begin
                    SweepAcqDataEn <= 1'b1;
                    LoadScParam    <= 1'b1;
                    state          <= WaitLoad;
                end
                WaitLoad: begin
                    SweepAcqDataEn <= 1'b0;
                    LoadScParam    <= 1'b0;
                    // Zero means still waiting for the loader
                    if (settleCount == '0) begin
                        if (ScConfigDone)
                            settleCount <= 1'b1;
                    end else if (settleCount == SC_SETTLE_CYCLES) begin
                        settleCount <= '0;
                        state       <= StartAcq;
                    end else begin
                        settleCount <= settleCount + 1'b1;
                    end
                end
                StartAcq: begin
                    SingleAcqStart <= 1'b1;
                    state          <= WaitPackage;
                end
                WaitPackage: begin
                    if (takePackage) begin
                        FifoRden <= 1'b1;
                        state    <= ReadWord;
                    end
                end
                ReadWord: begin
                    FifoRden       <= 1'b0;
                    SweepAcqDataEn <= 1'b0;
                    state          <= LatchWord;
                end
                LatchWord: begin
                    SweepAcqData <= FifoData;
                    state        <= OutWord;
                end
                OutWord: begin
                    SweepAcqDataEn <= 1'b1;
                    if (wordCount < WORDS_PER_PACKAGE - 1) begin
                        FifoRden  <= 1'b1;
                        wordCount <= wordCount + 1'b1;
                        state     <= ReadWord;
                    end else begin
                        wordCount <= '0;
                        state     <= CheckDacDone;
                    end
                end
                CheckDacDone: begin
                    SweepAcqDataEn <= 1'b0;
                    if ((pkgCount + 1'b1) < MaxPackageNumber) begin
                        pkgCount <= pkgCount + 1'b1;
                        state    <= WaitPackage;
                    end else begin
                        pkgCount       <= '0;
                        SingleAcqStart <= 1'b0;
                        OneDacDone     <= 1'b1;
                        state          <= CheckAllDone;
                    end
                end
                CheckAllDone: begin
                    OneDacDone <= 1'b0;
                    if (currentDac < EndDac0) begin
                        currentDac <= currentDac + 1'b1;
                        state      <= ParamOut;
                    end else begin
                        SweepAcqData <= TAIL_WORD;
                        state        <= TailOut;
                    end
                end
                TailOut: begin
                    SweepAcqDataEn <= 1'b1;
                    state          <= WaitTransmit;
                end
                WaitTransmit: begin
                    SweepAcqDataEn <= 1'b0;
                    if (DataTransmitDone) begin
                        AcqDone <= 1'b0;
                        state   <= Idle;
                    end else begin
                        AcqDone <= 1'b1;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Incoming word count and package bookkeeping
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            inWordCount <= '0;
            pkgDone     <= 1'b0;
        end else if (state == Idle) begin
            inWordCount <= '0;
            pkgDone     <= 1'b0;
        end else if (!ParallelDataEn) begin
            // Pause mid-package
            pkgDone <= 1'b0;
        end else if (inWordCount == WORDS_PER_PACKAGE - 1) begin
            inWordCount <= '0;
            pkgDone     <= 1'b1;
        end else begin
            inWordCount <= inWordCount + 1'b1;
            pkgDone     <= 1'b0;
        end
    end

    // Packages complete in the FIFO but not yet read out
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            pendingPkgs <= '0;
        end else if (state == Idle) begin
            pendingPkgs <= '0;
        end else begin
            case ({pkgDone, takePackage})
                2'b10:   pendingPkgs <= pendingPkgs + 1'b1;
                2'b01:   pendingPkgs <= pendingPkgs - 1'b1;
                default: pendingPkgs <= pendingPkgs;
            endcase
        end
    end

endmodule

/* sweepAcqTop.sv */
module sweepAcqTop import sweepAcqPkg::*; (
    input  logic                       Clk,
    input  logic                       reset_n,
    input  logic                       SweepStart,
    input  logic                       DataTransmitDone,
    input  logic [DAC_WIDTH-1:0]       StartDac0,
    input  logic [DAC_WIDTH-1:0]       EndDac0,
    input  logic [PKG_COUNT_WIDTH-1:0] MaxPackageNumber,
    input  logic [DATA_WIDTH-1:0]      ParallelData,
    input  logic                       ParallelDataEn,
    output logic                       SingleAcqStart,
    output logic                       OneDacDone,
    output logic                       AcqDone,
    output logic [DATA_WIDTH-1:0]      SweepAcqData,
    output logic                       SweepAcqDataEn,
    output logic                       ScSerialData,
    output logic                       ScSerialEn
);

    logic                  fifoRden;
    logic [DATA_WIDTH-1:0] fifoData;
    logic [DAC_WIDTH-1:0]  outDac0;
    logic                  loadScParam;
    logic                  scConfigDone;

    sweepAcqControl uControl (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .SweepStart       (SweepStart),
        .DataTransmitDone (DataTransmitDone),
        .StartDac0        (StartDac0),
        .EndDac0          (EndDac0),
        .MaxPackageNumber (MaxPackageNumber),
        .ParallelDataEn   (ParallelDataEn),
        .FifoData         (fifoData),
        .ScConfigDone     (scConfigDone),
        .FifoRden         (fifoRden),
        .OutDac0          (outDac0),
        .LoadScParam      (loadScParam),
        .SingleAcqStart   (SingleAcqStart),
        .OneDacDone       (OneDacDone),
        .AcqDone          (AcqDone),
        .SweepAcqData     (SweepAcqData),
        .SweepAcqDataEn   (SweepAcqDataEn)
    );

    // Buffers ASIC readout bursts
    acqDataFifo uFifo (
        .Clk            (Clk),
        .reset_n        (reset_n),
        .ParallelData   (ParallelData),
        .ParallelDataEn (ParallelDataEn),
        .FifoRden       (fifoRden),
        .FifoData       (fifoData)
    );

    scParamLoader uLoader (
        .Clk          (Clk),
        .reset_n      (reset_n),
        .OutDac0      (outDac0),
        .LoadScParam  (loadScParam),
        .ScSerialData (ScSerialData),
        .ScSerialEn   (ScSerialEn),
        .ScConfigDone (scConfigDone)
    );

endmodule

/* sweepAcqCheck_sva.sv */
module sweepAcqCheck (
    input logic Clk,
    input logic reset_n,
    input logic SweepAcqDataEn,
    input logic OneDacDone,
    input logic LoadScParam,
    input logic SingleAcqStart
);
    timeunit 1ns;
    timeprecision 100ps;

    int assertFailures = 0;

    // Each output word is a single-cycle strobe
    dataEnPulse: assert property (@(posedge Clk) disable iff (!reset_n)
        SweepAcqDataEn |=> !SweepAcqDataEn)
        else begin
            assertFailures++;
            $error("SweepAcqDataEn high in two consecutive cycles");
        end

    dacDonePulse: assert property (@(posedge Clk) disable iff (!reset_n)
        OneDacDone |=> !OneDacDone)
        else begin
            assertFailures++;
            $error("OneDacDone longer than one cycle");
        end

    // No reload of the chain during acquisition
    loadOutsideAcq: assert property (@(posedge Clk) disable iff (!reset_n)
        !(LoadScParam && SingleAcqStart))
        else begin
            assertFailures++;
            $error("LoadScParam high while SingleAcqStart is high");
        end

endmodule

bind sweepAcqControl sweepAcqCheck uCheck (
    .Clk            (Clk),
    .reset_n        (reset_n),
    .SweepAcqDataEn (SweepAcqDataEn),
    .OneDacDone     (OneDacDone),
    .LoadScParam    (LoadScParam),
    .SingleAcqStart (SingleAcqStart)
);

/* sweepAcqTb.sv */
module sweepAcqTb import sweepAcqPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic                       Clk;
    logic                       reset_n;
    logic                       SweepStart;
    logic                       DataTransmitDone;
    logic [DAC_WIDTH-1:0]       StartDac0;
    logic [DAC_WIDTH-1:0]       EndDac0;
    logic [PKG_COUNT_WIDTH-1:0] MaxPackageNumber;
    logic [DATA_WIDTH-1:0]      ParallelData;
    logic                       ParallelDataEn;
    logic                       SingleAcqStart;
    logic                       OneDacDone;
    logic                       AcqDone;
    logic [DATA_WIDTH-1:0]      SweepAcqData;
    logic                       SweepAcqDataEn;
    logic                       ScSerialData;
    logic                       ScSerialEn;

    // Sweep settings and readout words from the data file
    int                    testStart[$];
    int                    testEnd[$];
    int                    testPkgs[$];
    int                    testGap[$];
    logic [DATA_WIDTH-1:0] readoutWords[$];

    // Expected stream, parameter flags and slow control codes
    logic [DATA_WIDTH-1:0] expWords[$];
    bit                    expIsParam[$];
    int                    expCodes[$];
    logic [DAC_WIDTH-1:0]  serialBits;
    int                    serialCount;
    int                    dacDoneCount;
    int                    errors;
    int                    watchdogCycles;
    int                    seed;

    sweepAcqTop dut (.*);

    always #2 Clk = ~Clk;

    task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
        errors++;
        $display("[ERROR] %0.1f ns %s expected 0x%0h actual 0x%0h",
                 $realtime, name, expected, actual);
    endtask

    task automatic reportProblem(string msg);
        errors++;
        $display("%0.1f ns: %s", $realtime, msg);
    endtask

    function automatic bit nextDataLine(input int fd, output string line);
        while ($fgets(line, fd) != 0) begin
            // Skip comments and blank lines
            if (line.len() > 1 && line.substr(0, 0) != "#")
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic loadTests(output bit ok);
        int                    fd;
        string                 line;
        int                    s;
        int                    e;
        int                    m;
        int                    g;
        int                    limit;
        logic [DATA_WIDTH-1:0] w [WORDS_PER_PACKAGE];
        ok    = 1'b0;
        limit = 0;
        fd    = $fopen("sweepAcqTestdata.txt", "r");
        if (fd == 0) begin
            reportProblem("cannot open sweepAcqTestdata.txt");
            return;
        end
        while (nextDataLine(fd, line)) begin
            if ($sscanf(line, "%d %d %d %d", s, e, m, g) != 4) begin
                reportProblem("bad sweep settings line in the test data");
                $fclose(fd);
                return;
            end
            testStart.push_back(s);
            testEnd.push_back(e);
            testPkgs.push_back(m);
            testGap.push_back(g);
            limit += 200 * m * (e - s + 1) + 500 * (e - s + 1);
            repeat ((e - s + 1) * m) begin
                if (!nextDataLine(fd, line) ||
                    $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", w[0], w[1], w[2],
                            w[3], w[4], w[5], w[6], w[7], w[8], w[9]) != WORDS_PER_PACKAGE) begin
                    reportProblem("readout words missing in the test data");
                    $fclose(fd);
                    return;
                end
                foreach (w[i])
                    readoutWords.push_back(w[i]);
            end
        end
        $fclose(fd);
        ok = (testStart.size() > 0);
        if (!ok)
            reportProblem("the test data holds no sweep");
        watchdogCycles = limit;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Transmitter and slow control monitors
    //////////////////////////////////////////////////////////////////////
    task automatic checkOutputWord();
        logic [DATA_WIDTH-1:0] expected;
        bit                    isParam;
        if (expWords.size() == 0) begin
            reportProblem($sformatf("extra output word 0x%h after the sweep", SweepAcqData));
            return;
        end
        expected = expWords.pop_front();
        isParam  = expIsParam.pop_front();
        if (SweepAcqData !== expected)
            reportMismatch("SweepAcqData", expected, SweepAcqData);
        // Acquisition is stopped while a new code is announced
        if (isParam && SingleAcqStart !== 1'b0)
            reportMismatch("SingleAcqStart", 0, SingleAcqStart);
    endtask

    task automatic collectSerialBit();
        int expected;
        // Chain receives the code LSB first
        serialBits[serialCount] = ScSerialData;
        serialCount++;
        if (serialCount == DAC_WIDTH) begin
            serialCount = 0;
            if (expCodes.size() == 0) begin
                reportProblem("slow control load without a pending DAC code");
            end else begin
                expected = expCodes.pop_front();
                if (serialBits !== expected[DAC_WIDTH-1:0])
                    reportMismatch("ScSerialData", expected, serialBits);
            end
        end
    endtask

    always @(negedge Clk) begin
        if (reset_n) begin
            if (SweepAcqDataEn)
                checkOutputWord();
            if (OneDacDone)
                dacDoneCount++;
            if (ScSerialEn)
                collectSerialBit();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // ASIC model and sweep sequence
    //////////////////////////////////////////////////////////////////////
    task automatic sendPackages(int wordBase, int nCodes, int nPkgs, int gap);
        int idx;
        int pkgIdx;
        idx    = wordBase;
        pkgIdx = 0;
        for (int c = 0; c < nCodes; c++) begin
            do @(negedge Clk); while (SingleAcqStart !== 1'b1);
            for (int p = 0; p < nPkgs; p++) begin
                for (int w = 0; w < WORDS_PER_PACKAGE; w++) begin
                    // Every tenth package stalls once half way
                    if (pkgIdx % 10 == 0 && w == WORDS_PER_PACKAGE / 2) begin
                        @(posedge Clk);
                        #0.5;
                        ParallelDataEn = 1'b0;
                    end
                    @(posedge Clk);
                    #0.5;
                    ParallelData   = readoutWords[idx];
                    ParallelDataEn = 1'b1;
                    idx++;
                end
                @(posedge Clk);
                #0.5;
                ParallelDataEn = 1'b0;
                repeat (gap - 1)
                    @(posedge Clk);
                pkgIdx++;
            end
            do @(negedge Clk); while (SingleAcqStart !== 1'b0);
        end
    endtask

    task automatic finishSweep();
        int delay;
        do @(negedge Clk); while (AcqDone !== 1'b1);
        if (expWords.size() != 0)
            reportProblem($sformatf("AcqDone rose with %0d output words missing",
                                    expWords.size()));
        @(posedge Clk);
        #0.5;
        SweepStart = 1'b0;
        delay = 2 + ($unsigned($random(seed)) % 4);
        repeat (delay) begin
            @(negedge Clk);
            if (AcqDone !== 1'b1)
                reportMismatch("AcqDone", 1, AcqDone);
        end
        @(posedge Clk);
        #0.5;
        DataTransmitDone = 1'b1;
        @(posedge Clk);
        #0.5;
        DataTransmitDone = 1'b0;
        @(negedge Clk);
        if (AcqDone !== 1'b0)
            reportMismatch("AcqDone", 0, AcqDone);
    endtask

    task automatic runSweep(int t, int wordBase);
        int                   nCodes;
        int                   idx;
        logic [DAC_WIDTH-1:0] code;
        nCodes = testEnd[t] - testStart[t] + 1;
        idx    = wordBase;
        expWords.push_back(HEADER_WORD);
        expIsParam.push_back(1'b0);
        for (int c = 0; c < nCodes; c++) begin
            code = testStart[t] + c;
            expWords.push_back({PARAM_TAG, 2'b00, code});
            expIsParam.push_back(1'b1);
            expCodes.push_back(code);
            repeat (testPkgs[t] * WORDS_PER_PACKAGE) begin
                expWords.push_back(readoutWords[idx]);
                expIsParam.push_back(1'b0);
                idx++;
            end
        end
        expWords.push_back(TAIL_WORD);
        expIsParam.push_back(1'b0);
        dacDoneCount = 0;
        @(posedge Clk);
        #0.5;
        StartDac0        = testStart[t];
        EndDac0          = testEnd[t];
        MaxPackageNumber = testPkgs[t];
        @(posedge Clk);
        #0.5;
        SweepStart = 1'b1;
        fork
            sendPackages(wordBase, nCodes, testPkgs[t], testGap[t]);
            finishSweep();
        join
        if (dacDoneCount != nCodes)
            reportMismatch("OneDacDone", nCodes, dacDoneCount);
        if (expCodes.size() != 0)
            reportProblem($sformatf("%0d DAC codes never loaded", expCodes.size()));
        expWords.delete();
        expIsParam.delete();
        expCodes.delete();
    endtask

    initial begin
        bit ok;
        int wordBase;
        int total;
        Clk              = 1'b0;
        reset_n          = 1'b0;
        SweepStart       = 1'b0;
        DataTransmitDone = 1'b0;
        StartDac0        = '0;
        EndDac0          = '0;
        MaxPackageNumber = '0;
        ParallelData     = '0;
        ParallelDataEn   = 1'b0;
        errors           = 0;
        serialCount      = 0;
        dacDoneCount     = 0;
        watchdogCycles   = 0;
        seed             = 56234;
        wordBase         = 0;
        loadTests(ok);
        repeat (2) @(posedge Clk);
        #0.5;
        reset_n = 1'b1;
        if (ok) begin
            for (int t = 0; t < testStart.size(); t++) begin
                runSweep(t, wordBase);
                wordBase += (testEnd[t] - testStart[t] + 1) * testPkgs[t] * WORDS_PER_PACKAGE;
            end
        end
        total = errors + dut.uControl.uCheck.assertFailures;
        $display("Error count: %0d (%0d from assertions)", total,
                 dut.uControl.uCheck.assertFailures);
        if (total == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // Watchdog sized from the data file
    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge Clk);
        $display("Timeout: sweeps did not complete within %0d cycles", watchdogCycles);
        $display("Error count: %0d", errors + 1);
        $display("Checks failed");
        $finish;
    end

endmodule

/* sweepAcqTestdata.txt */
# Sweep line: StartDac0 EndDac0 MaxPackageNumber Gap, all decimal
# Then one line per package of ten hex readout words, in sweep order
# Three codes, two packages per code
5 7 2 30
a000 a001 a002 a003 a004 a005 a006 a007 a008 a009
a010 a011 a012 a013 a014 a015 a016 a017 a018 a019
a020 a021 a022 a023 a024 a025 a026 a027 a028 a029
a030 a031 a032 a033 a034 a035 a036 a037 a038 a039
a040 a041 a042 a043 a044 a045 a046 a047 a048 a049
a050 a051 a052 a053 a054 a055 a056 a057 a058 a059
# Single code at the top of the range, three packages
1023 1023 3 24
ffff 0000 8001 7ffe 5341 ff45 d3ff 1234 abcd 00ff
b010 b011 b012 b013 b014 b015 b016 b017 b018 b019
b020 b021 b022 b023 b024 b025 b026 b027 b028 b029
# Two codes from zero, one package each
0 1 1 40
c000 c001 c002 c003 c004 c005 c006 c007 c008 c009
c010 c011 c012 c013 c014 c015 c016 c017 c018 c019

/* vlog.f */
sweepAcqPkg.sv
acqDataFifo.sv
scParamLoader.sv
sweepAcqControl.sv
sweepAcqTop.sv
sweepAcqCheck_sva.sv
sweepAcqTb.sv

/* Bender.yml */
package:
  name: sweep_acq

sources:
  # Design
  - files:
      - sweepAcqPkg.sv
      - acqDataFifo.sv
      - scParamLoader.sv
      - sweepAcqControl.sv
      - sweepAcqTop.sv
  # Testbench
  - target: test
    files:
      - sweepAcqCheck_sva.sv
      - sweepAcqTb.sv
